//--- all.f
hdl/alu_pkg.sv
hdl/alu_exec_if.sv
hdl/alu_decode.sv
hdl/alu_adder.sv
hdl/alu_cond_eval.sv
hdl/alu_datapath.sv
hdl/alu_retire.sv
hdl/alu_top.sv
bench/alu_tb.sv

//--- bench/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;

  localparam int XLEN       = alu_pkg::XLEN;
  localparam int RST_CYCLES = 8;
  localparam int N_EDGE     = 8;
  localparam int N_COND     = 16 * 4 * 2;
  localparam int N_RANDOM   = 2000;
  localparam int MAX_CYCLES = RST_CYCLES + N_EDGE * N_EDGE * 4 + N_COND + N_RANDOM + 16;

  typedef struct packed {
    logic [XLEN-1:0] res;
    alu_pkg::flags_t flags;
    logic            we;
    int              cycle;  // cycle the result is due
  } expect_t;

  logic                 clk;
  logic                 rst;
  logic                 in_valid;
  alu_pkg::alu_op_t     op;
  alu_pkg::cond_t       cond;
  logic                 set_flags;
  logic [XLEN-1:0]      src_a;
  logic [XLEN-1:0]      src_b;
  alu_pkg::flags_t      flags_in;
  logic                 out_valid;
  logic [XLEN-1:0]      result;
  alu_pkg::flags_t      flags_out;
  logic                 flags_we;

  expect_t         exp_q[$];
  int              cyc = 0;
  int              err_result = 0;
  int              err_flags = 0;
  int              err_other = 0;
  logic [XLEN-1:0] edge_val [N_EDGE];

  alu_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (op),
    .cond      (cond),
    .set_flags (set_flags),
    .src_a     (src_a),
    .src_b     (src_b),
    .flags_in  (flags_in),
    .out_valid (out_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // odd codes invert the predicate of their pair
  function automatic logic cond_holds(alu_pkg::flags_t f, alu_pkg::cond_t c);
    logic t;
    case (c[3:1])
      3'd0:    t = f.z;
      3'd1:    t = f.s;
      3'd2:    t = !f.c && !f.z;          // ugt
      3'd3:    t = !f.c;                  // uge
      3'd4:    t = (f.s == f.o) && !f.z;  // sgt
      3'd5:    t = (f.s == f.o);          // sge
      3'd6:    t = f.o;
      default: t = f.p;
    endcase
    return (c[0] == 1'b0) ? t : !t;
  endfunction

  function automatic expect_t predict(alu_pkg::alu_op_t opc, alu_pkg::cond_t cc, logic sf,
                                      logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                                      alu_pkg::flags_t fin);
    logic [XLEN-1:0]      mask;
    logic [XLEN-1:0]      am;
    logic [XLEN-1:0]      bm;
    logic [XLEN-1:0]      r;
    logic [XLEN:0]        wide;
    logic [5:0]           top;
    logic                 narrow;
    logic                 take;
    logic                 cf;
    logic                 af;
    logic                 of;
    alu_pkg::flag_class_t cls;
    expect_t              e;
    e = '0;
    cf = 1'b0;
    af = 1'b0;
    of = 1'b0;
    cls = alu_pkg::FC_NONE;
    case (opc)
      alu_pkg::OP_ADD32, alu_pkg::OP_SUB32, alu_pkg::OP_AND32,
      alu_pkg::OP_OR32, alu_pkg::OP_XOR32, alu_pkg::OP_MOV32: narrow = 1'b1;
      default: narrow = 1'b0;
    endcase
    mask = narrow ? 64'h0000_0000_ffff_ffff : '1;
    top  = narrow ? 6'd31 : 6'd63;
    am   = a & mask;
    bm   = b & mask;
    take = cond_holds(fin, cc);
    case (opc)
      alu_pkg::OP_ADD64, alu_pkg::OP_ADD32: begin
        wide = {1'b0, am} + {1'b0, bm};
        r    = wide[XLEN-1:0] & mask;
        cf   = narrow ? wide[32] : wide[XLEN];
        af   = ({1'b0, am[3:0]} + {1'b0, bm[3:0]}) > 5'd15;
        of   = (am[top] == bm[top]) && (r[top] != am[top]);
        cls  = alu_pkg::FC_ADD;
      end
      alu_pkg::OP_SUB64, alu_pkg::OP_SUB32: begin
        r   = (am - bm) & mask;
        cf  = am < bm;            // borrow
        af  = am[3:0] < bm[3:0];
        of  = (am[top] != bm[top]) && (r[top] != am[top]);
        cls = alu_pkg::FC_SUB;
      end
      alu_pkg::OP_AND64, alu_pkg::OP_AND32: begin
        r   = am & bm;
        cls = alu_pkg::FC_LOGIC;
      end
      alu_pkg::OP_OR64, alu_pkg::OP_OR32: begin
        r   = am | bm;
        cls = alu_pkg::FC_LOGIC;
      end
      alu_pkg::OP_XOR64, alu_pkg::OP_XOR32: begin
        r   = am ^ bm;
        cls = alu_pkg::FC_LOGIC;
      end
      alu_pkg::OP_MOV64, alu_pkg::OP_MOV32: r = bm;
      alu_pkg::OP_ZXT8:  r = XLEN'(b[7:0]);
      alu_pkg::OP_ZXT16: r = XLEN'(b[15:0]);
      alu_pkg::OP_SXT8:  r = XLEN'($signed(b[7:0]));
      alu_pkg::OP_SXT16: r = XLEN'($signed(b[15:0]));
      alu_pkg::OP_SXT32: r = XLEN'($signed(b[31:0]));
      alu_pkg::OP_CMOV:  r = take ? b : a;
      alu_pkg::OP_CSET:  r = XLEN'(take);
      alu_pkg::OP_CSAND: r = XLEN'(take && a[0]);
      alu_pkg::OP_CSOR:  r = XLEN'(take || a[0]);
      default:           r = '0;
    endcase
    e.res = r;
    e.we  = sf && (cls != alu_pkg::FC_NONE);
    if (e.we) begin
      e.flags.c = cf;
      e.flags.o = of;
      e.flags.a = af;
      e.flags.s = r[top];
      e.flags.z = (r == '0);
      e.flags.p = ~^r[7:0];
    end
    return e;
  endfunction

  task automatic issue(input logic v, input alu_pkg::alu_op_t opc, input alu_pkg::cond_t cc,
                       input logic sf, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                       input alu_pkg::flags_t fin);
    expect_t e;
    @(posedge clk);
    #10;
    in_valid  = v;
    op        = opc;
    cond      = cc;
    set_flags = sf;
    src_a     = a;
    src_b     = b;
    flags_in  = fin;
    if (v) begin
      e = predict(opc, cc, sf, a, b, fin);
      e.cycle = cyc + 1;
      exp_q.push_back(e);
    end
  endtask

  function automatic alu_pkg::flags_t random_flags();
    return alu_pkg::flags_t'(6'($urandom));
  endfunction

  function automatic logic [XLEN-1:0] random_word();
    return {$urandom, $urandom};
  endfunction

  task automatic check_outputs();
    expect_t e;
    if (exp_q.size() != 0 && exp_q[0].cycle <= cyc) begin
      e = exp_q.pop_front();
      if (out_valid !== 1'b1) begin
        $display("operation due in cycle %0d did not come out", e.cycle);
        err_other++;
      end
      if (result !== e.res) begin
        $display("ERR result exp=%h got=%h", e.res, result);
        err_result++;
      end
      if (flags_out !== e.flags) begin
        $display("ERR flags_out exp=%h got=%h", e.flags, flags_out);
        err_flags++;
      end
      if (flags_we !== e.we) begin
        $display("ERR flags_we exp=%h got=%h", e.we, flags_we);
        err_flags++;
      end
    end else if (out_valid !== 1'b0 || flags_we !== 1'b0) begin
      $display("output active in cycle %0d with no operation due", cyc);
      err_other++;
    end
  endtask

  initial begin
    @(posedge clk);
    forever begin
      @(negedge clk);
      check_outputs();
    end
  end

  initial begin
    wait (cyc >= MAX_CYCLES);
    $display("timeout in cycle %0d with %0d operations outstanding", cyc, exp_q.size());
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int unsigned     seed_ret;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    seed_ret  = $urandom(99);
    rst       = 1'b1;
    in_valid  = 1'b1;  // flag-setting add offered all through reset
    op        = alu_pkg::OP_ADD64;
    cond      = alu_pkg::Z;
    set_flags = 1'b1;
    src_a     = '0;
    src_b     = '0;
    flags_in  = '0;
    edge_val[0] = 64'h0;
    edge_val[1] = 64'h1;
    edge_val[2] = 64'hffff_ffff_ffff_ffff;
    edge_val[3] = 64'h7fff_ffff_ffff_ffff;
    edge_val[4] = 64'h8000_0000_0000_0000;
    edge_val[5] = 64'h0000_0000_ffff_ffff;
    edge_val[6] = 64'h0000_0000_7fff_ffff;
    edge_val[7] = 64'hffff_ffff_8000_0000;
    repeat (RST_CYCLES) @(posedge clk);
    #10;
    rst      = 1'b0;
    in_valid = 1'b0;

    // edge operands with equal pairs on the diagonal
    for (int i = 0; i < N_EDGE; i++) begin
      for (int j = 0; j < N_EDGE; j++) begin
        issue(1'b1, alu_pkg::OP_ADD64, alu_pkg::Z, 1'b1, edge_val[i], edge_val[j], '0);
        issue(1'b1, alu_pkg::OP_ADD32, alu_pkg::Z, 1'b1, edge_val[i], edge_val[j], '0);
        issue(1'b1, alu_pkg::OP_SUB64, alu_pkg::Z, 1'b1, edge_val[i], edge_val[j], '0);
        issue(1'b1, alu_pkg::OP_SUB32, alu_pkg::Z, 1'b1, edge_val[i], edge_val[j], '0);
      end
    end

    for (int c = 0; c < 16; c++) begin
      for (int k = 0; k < 2; k++) begin
        a = random_word();
        b = random_word();
        issue(1'b1, alu_pkg::OP_CMOV, alu_pkg::cond_t'(4'(c)), 1'b1, a, b, random_flags());
        issue(1'b1, alu_pkg::OP_CSET, alu_pkg::cond_t'(4'(c)), 1'b1, a, b, random_flags());
        issue(1'b1, alu_pkg::OP_CSAND, alu_pkg::cond_t'(4'(c)), 1'b0, a, b, random_flags());
        issue(1'b1, alu_pkg::OP_CSOR, alu_pkg::cond_t'(4'(c)), 1'b1, a, b, random_flags());
      end
    end

    // codes 21 and 22 are unused
    for (int n = 0; n < N_RANDOM; n++) begin
      a = random_word();
      case ($urandom % 4)
        0:       b = a;
        1:       b = XLEN'($urandom % 16);
        default: b = random_word();
      endcase
      issue(($urandom % 5) != 0, alu_pkg::alu_op_t'(5'($urandom % 23)),
            alu_pkg::cond_t'(4'($urandom)), 1'($urandom), a, b, random_flags());
    end

    issue(1'b0, alu_pkg::OP_ADD64, alu_pkg::Z, 1'b0, '0, '0, '0);
    while (exp_q.size() != 0) @(posedge clk);

    $display("errors: result %0d, flags %0d, other %0d", err_result, err_flags, err_other);
    if (err_result + err_flags + err_other == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/alu_adder.sv
`timescale 1ns/1ps

module alu_adder (
  input  logic [alu_pkg::XLEN-1:0] src_a,
  input  logic [alu_pkg::XLEN-1:0] src_b,
  input  logic                     sub,
  output logic [alu_pkg::XLEN-1:0] sum,
  output logic                     carry4,
  output logic                     carry32,
  output logic                     carry64,
  output logic                     ovf32,
  output logic                     ovf64
);

  localparam int HI_W = alu_pkg::XLEN - 32;

  logic [alu_pkg::XLEN-1:0] b_eff;
  logic [4:0]               nib_sum;   // bits 3:0 plus carry
  logic [28:0]              mid_sum;   // bits 31:4 plus carry
  logic [HI_W:0]            hi_sum;    // bits 63:32 plus carry

  // a - b as a + ~b + 1
  assign b_eff = sub ? ~src_b : src_b;

  // split so the nibble and dword carries fall out directly
  assign nib_sum = {1'b0, src_a[3:0]} + {1'b0, b_eff[3:0]} + {4'b0, sub};
  assign mid_sum = {1'b0, src_a[31:4]} + {1'b0, b_eff[31:4]} + {28'b0, nib_sum[4]};
  assign hi_sum  = {1'b0, src_a[alu_pkg::XLEN-1:32]} + {1'b0, b_eff[alu_pkg::XLEN-1:32]}
                 + {{HI_W{1'b0}}, mid_sum[28]};

  assign sum     = {hi_sum[HI_W-1:0], mid_sum[27:0], nib_sum[3:0]};
  assign carry4  = nib_sum[4];
  assign carry32 = mid_sum[28];
  assign carry64 = hi_sum[HI_W];

  // same sign in, other sign out
  assign ovf32 = (src_a[31] == b_eff[31]) && (sum[31] != src_a[31]);
  assign ovf64 = (src_a[alu_pkg::XLEN-1] == b_eff[alu_pkg::XLEN-1])
              && (sum[alu_pkg::XLEN-1] != src_a[alu_pkg::XLEN-1]);

endmodule

//--- hdl/alu_cond_eval.sv
`timescale 1ns/1ps

module alu_cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            take
);

  logic sx;  // signed less-than

  assign sx = flags.s ^ flags.o;

  always_comb begin
    take = 1'b0;
    case (cond)
      alu_pkg::Z:   take = flags.z;
      alu_pkg::NZ:  take = ~flags.z;
      alu_pkg::S:   take = flags.s;
      alu_pkg::NS:  take = ~flags.s;
      alu_pkg::UGT: take = ~(flags.c | flags.z);
      alu_pkg::ULE: take = flags.c | flags.z;
      alu_pkg::UGE: take = ~flags.c;
      alu_pkg::ULT: take = flags.c;
      alu_pkg::SGT: take = ~(sx | flags.z);
      alu_pkg::SLE: take = sx | flags.z;
      alu_pkg::SGE: take = ~sx;
      alu_pkg::SLT: take = sx;
      alu_pkg::O:   take = flags.o;
      alu_pkg::NO:  take = ~flags.o;
      alu_pkg::P:   take = flags.p;
      alu_pkg::NP:  take = ~flags.p;
      default:      take = 1'b0;
    endcase
  end

endmodule

//--- hdl/alu_datapath.sv
`timescale 1ns/1ps

module alu_datapath (
  input  logic                     in_valid,
  input  alu_pkg::alu_op_t         op,
  input  alu_pkg::cond_t           cond,
  input  alu_pkg::flags_t          flags_in,
  input  logic [alu_pkg::XLEN-1:0] src_a,
  input  logic [alu_pkg::XLEN-1:0] src_b,
  input  logic                     add_en,
  input  logic                     sub,
  input  logic [1:0]               logic_sel,
  input  logic                     width32,
  input  alu_pkg::flag_class_t     fclass,
  alu_exec_if.exec                 exec
);

  localparam int XLEN = alu_pkg::XLEN;

  logic [XLEN-1:0] sum;
  logic            carry4;
  logic            carry32;
  logic            carry64;
  logic            ovf32;
  logic            ovf64;
  logic            take;
  logic [XLEN-1:0] logic_val;
  logic [XLEN-1:0] raw;

  alu_adder u_adder (
    .src_a   (src_a),
    .src_b   (src_b),
    .sub     (sub),
    .sum     (sum),
    .carry4  (carry4),
    .carry32 (carry32),
    .carry64 (carry64),
    .ovf32   (ovf32),
    .ovf64   (ovf64)
  );

  alu_cond_eval u_cond (
    .flags (flags_in),
    .cond  (cond),
    .take  (take)
  );

  always_comb begin
    case (logic_sel)
      2'd1:    logic_val = src_a & src_b;
      2'd2:    logic_val = src_a | src_b;
      2'd3:    logic_val = src_a ^ src_b;
      default: logic_val = '0;
    endcase
  end

  always_comb begin
    if (add_en) begin
      raw = sum;
    end else if (logic_sel != 2'd0) begin
      raw = logic_val;
    end else begin
      case (op)
        alu_pkg::OP_MOV64, alu_pkg::OP_MOV32: raw = src_b;
        alu_pkg::OP_ZXT8:  raw = {{(XLEN-8){1'b0}}, src_b[7:0]};
        alu_pkg::OP_ZXT16: raw = {{(XLEN-16){1'b0}}, src_b[15:0]};
        alu_pkg::OP_SXT8:  raw = {{(XLEN-8){src_b[7]}}, src_b[7:0]};
        alu_pkg::OP_SXT16: raw = {{(XLEN-16){src_b[15]}}, src_b[15:0]};
        alu_pkg::OP_SXT32: raw = {{(XLEN-32){src_b[31]}}, src_b[31:0]};
        alu_pkg::OP_CMOV:  raw = take ? src_b : src_a;
        alu_pkg::OP_CSET:  raw = {{(XLEN-1){1'b0}}, take};
        alu_pkg::OP_CSAND: raw = {{(XLEN-1){1'b0}}, take & src_a[0]};
        alu_pkg::OP_CSOR:  raw = {{(XLEN-1){1'b0}}, take | src_a[0]};
        default:           raw = '0;
      endcase
    end
  end

  // 32-bit ops zero-extend into the upper half
  assign exec.value   = width32 ? {{(XLEN-32){1'b0}}, raw[31:0]} : raw;
  assign exec.valid   = in_valid;
  assign exec.width32 = width32;
  assign exec.fclass  = fclass;
  assign exec.carry4  = carry4;
  assign exec.carry32 = carry32;
  assign exec.carry64 = carry64;
  assign exec.ovf32   = ovf32;
  assign exec.ovf64   = ovf64;

endmodule

//--- hdl/alu_decode.sv
`timescale 1ns/1ps

module alu_decode (
  input  alu_pkg::alu_op_t     op,
  input  logic                 set_flags,
  output logic                 add_en,
  output logic                 sub,
  output logic [1:0]           logic_sel,  // 0 none, 1 and, 2 or, 3 xor
  output logic                 width32,
  output alu_pkg::flag_class_t fclass
);

  alu_pkg::flag_class_t op_class;

  always_comb begin
    add_en    = 1'b0;
    sub       = 1'b0;
    logic_sel = 2'd0;
    width32   = 1'b0;
    op_class  = alu_pkg::FC_NONE;
    case (op)
      alu_pkg::OP_ADD64, alu_pkg::OP_ADD32: begin
        add_en   = 1'b1;
        op_class = alu_pkg::FC_ADD;
      end
      alu_pkg::OP_SUB64, alu_pkg::OP_SUB32: begin
        add_en   = 1'b1;
        sub      = 1'b1;
        op_class = alu_pkg::FC_SUB;
      end
      alu_pkg::OP_AND64, alu_pkg::OP_AND32: begin
        logic_sel = 2'd1;
        op_class  = alu_pkg::FC_LOGIC;
      end
      alu_pkg::OP_OR64, alu_pkg::OP_OR32: begin
        logic_sel = 2'd2;
        op_class  = alu_pkg::FC_LOGIC;
      end
      alu_pkg::OP_XOR64, alu_pkg::OP_XOR32: begin
        logic_sel = 2'd3;
        op_class  = alu_pkg::FC_LOGIC;
      end
      default: ;  // moves, extends and conditionals touch no flags
    endcase

    case (op)
      alu_pkg::OP_ADD32, alu_pkg::OP_SUB32, alu_pkg::OP_AND32,
      alu_pkg::OP_OR32, alu_pkg::OP_XOR32, alu_pkg::OP_MOV32:
        width32 = 1'b1;
      default: width32 = 1'b0;
    endcase
  end

  // flag update can be suppressed per op
  assign fclass = set_flags ? op_class : alu_pkg::FC_NONE;

endmodule

//--- hdl/alu_exec_if.sv
`timescale 1ns/1ps

interface alu_exec_if;

  logic                       valid;
  logic                       width32;
  alu_pkg::flag_class_t       fclass;
  logic [alu_pkg::XLEN-1:0]   value;    // already masked for 32-bit ops
  logic                       carry4;
  logic                       carry32;
  logic                       carry64;
  logic                       ovf32;
  logic                       ovf64;

  modport exec (
    output valid, width32, fclass, value,
    output carry4, carry32, carry64, ovf32, ovf64
  );

  modport retire (
    input valid, width32, fclass, value,
    input carry4, carry32, carry64, ovf32, ovf64
  );

endinterface

//--- hdl/alu_pkg.sv
package alu_pkg;

  localparam int XLEN = 64;

  // operation codes, anything unlisted returns 0 with no flag write
  typedef enum logic [4:0] {
    OP_ADD64 = 5'd0,
    OP_ADD32 = 5'd1,
    OP_SUB64 = 5'd2,
    OP_SUB32 = 5'd3,
    OP_AND64 = 5'd4,
    OP_AND32 = 5'd5,
    OP_OR64  = 5'd6,
    OP_OR32  = 5'd7,
    OP_XOR64 = 5'd8,
    OP_XOR32 = 5'd9,
    OP_MOV64 = 5'd10,
    OP_MOV32 = 5'd11,
    OP_ZXT8  = 5'd12,
    OP_ZXT16 = 5'd13,
    OP_SXT8  = 5'd14,
    OP_SXT16 = 5'd15,
    OP_SXT32 = 5'd16,
    OP_CMOV  = 5'd17,
    OP_CSET  = 5'd18,
    OP_CSAND = 5'd19,
    OP_CSOR  = 5'd20
  } alu_op_t;

  // x86 style conditions, odd codes are the inverse of the even ones
  typedef enum logic [3:0] {
    Z   = 4'd0,
    NZ  = 4'd1,
    S   = 4'd2,
    NS  = 4'd3,
    UGT = 4'd4,
    ULE = 4'd5,
    UGE = 4'd6,
    ULT = 4'd7,
    SGT = 4'd8,
    SLE = 4'd9,
    SGE = 4'd10,
    SLT = 4'd11,
    O   = 4'd12,
    NO  = 4'd13,
    P   = 4'd14,
    NP  = 4'd15
  } cond_t;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  typedef enum logic [1:0] {
    FC_NONE  = 2'd0,
    FC_ADD   = 2'd1,
    FC_SUB   = 2'd2,
    FC_LOGIC = 2'd3
  } flag_class_t;

endpackage

//--- hdl/alu_retire.sv
`timescale 1ns/1ps

module alu_retire (
  input  logic                     clk,
  input  logic                     rst,
  alu_exec_if.retire               exec,
  output logic                     out_valid,
  output logic [alu_pkg::XLEN-1:0] result,
  output alu_pkg::flags_t          flags_out,
  output logic                     flags_we
);

  logic            zero;
  logic            sign;
  logic            parity;
  logic            carry;
  logic            ovf;
  logic            we;
  alu_pkg::flags_t flag_word;

  assign zero   = exec.width32 ? (exec.value[31:0] == 32'b0) : (exec.value == '0);
  assign sign   = exec.width32 ? exec.value[31] : exec.value[alu_pkg::XLEN-1];
  assign parity = ~^exec.value[7:0];  // even count of ones in low byte

  assign carry = exec.width32 ? exec.carry32 : exec.carry64;
  assign ovf   = exec.width32 ? exec.ovf32 : exec.ovf64;

  always_comb begin
    flag_word = '0;
    case (exec.fclass)
      alu_pkg::FC_ADD: begin
        flag_word.c = carry;
        flag_word.a = exec.carry4;
        flag_word.o = ovf;
      end
      alu_pkg::FC_SUB: begin
        flag_word.c = ~carry;        // borrow
        flag_word.a = ~exec.carry4;
        flag_word.o = ovf;
      end
      default: ;  // logic ops leave c, o, a clear
    endcase

    if (exec.fclass != alu_pkg::FC_NONE) begin
      flag_word.s = sign;
      flag_word.z = zero;
      flag_word.p = parity;
    end
  end

  assign we = exec.valid && (exec.fclass != alu_pkg::FC_NONE);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      flags_we  <= 1'b0;
      result    <= '0;
      flags_out <= '0;
    end else begin
      out_valid <= exec.valid;
      flags_we  <= we;
      result    <= exec.value;
      flags_out <= flag_word;
    end
  end

endmodule

//--- hdl/alu_top.sv
`timescale 1ns/1ps

module alu_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  alu_pkg::alu_op_t         op,
  input  alu_pkg::cond_t           cond,
  input  logic                     set_flags,
  input  logic [alu_pkg::XLEN-1:0] src_a,
  input  logic [alu_pkg::XLEN-1:0] src_b,
  input  alu_pkg::flags_t          flags_in,
  output logic                     out_valid,
  output logic [alu_pkg::XLEN-1:0] result,
  output alu_pkg::flags_t          flags_out,
  output logic                     flags_we
);

  logic                 add_en;
  logic                 sub;
  logic [1:0]           logic_sel;
  logic                 width32;
  alu_pkg::flag_class_t fclass;

  alu_exec_if exec_bus ();

  alu_decode u_decode (
    .op        (op),
    .set_flags (set_flags),
    .add_en    (add_en),
    .sub       (sub),
    .logic_sel (logic_sel),
    .width32   (width32),
    .fclass    (fclass)
  );

  alu_datapath u_datapath (
    .in_valid  (in_valid),
    .op        (op),
    .cond      (cond),
    .flags_in  (flags_in),
    .src_a     (src_a),
    .src_b     (src_b),
    .add_en    (add_en),
    .sub       (sub),
    .logic_sel (logic_sel),
    .width32   (width32),
    .fclass    (fclass),
    .exec      (exec_bus.exec)
  );

  alu_retire u_retire (
    .clk       (clk),
    .rst       (rst),
    .exec      (exec_bus.retire),
    .out_valid (out_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module alu_tb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Valu_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
